//--- rvdec_defs.svh
// Shared macros for the instruction decode stage, included by the package and the RTL modules
`ifndef RVDEC_DEFS_SVH
`define RVDEC_DEFS_SVH

//////////////////////////////
// Instruction word
//////////////////////////////

// Width of one fetched instruction word
`define RVDEC_ILEN 32

//////////////////////////////
// Custom system extension
//////////////////////////////

// Upper six bits that mark WFE inside the SYSTEM opcode
// Reserved fields of the word must all be zero as well
`define RVDEC_WFE_FUNCT6 6'b100011

// Custom decoder enable
// 1 builds the WFE decoder
// 0 leaves it out so WFE decodes as illegal
`define RVDEC_X_EXT_EN 1

`endif

//--- rvdec_pkg.sv
// Types shared by the decode stage: opcode and operation enums, control structs, illegal constant
`include "rvdec_defs.svh"

package rvdec_pkg;

  //////////////////////////////
  // Opcode field
  //////////////////////////////

  // Only the three groups handled by this stage
  // Any other value in bits 6..0 is illegal
  typedef enum logic [6:0] {
    OPCODE_OP_IMM = 7'h13,
    OPCODE_OP     = 7'h33,
    OPCODE_SYSTEM = 7'h73
  } opcode_e;

  //////////////////////////////
  // Operation codes
  //////////////////////////////

  // Integer ALU operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // Multiply/divide operations
  // Encoding equals funct3 of the M extension
  typedef enum logic [2:0] {
    MUL_MUL    = 3'b000,
    MUL_MULH   = 3'b001,
    MUL_MULHSU = 3'b010,
    MUL_MULHU  = 3'b011,
    MUL_DIV    = 3'b100,
    MUL_DIVU   = 3'b101,
    MUL_REM    = 3'b110,
    MUL_REMU   = 3'b111
  } mul_op_e;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // Request from the controller
  // No-sleep is raised while debug forbids entering sleep
  typedef struct packed {
    logic debug_wfi_no_sleep;
  } ctrl_fsm_t;

  // Decoded control, produced by every sub-decoder
  typedef struct packed {
    logic    alu_en;
    alu_op_e alu_op;
    logic    alu_op_b_imm;
    logic    mul_en;
    mul_op_e mul_op;
    logic    sys_en;
    logic    sys_wfe_insn;
    logic    rf_we;
    logic    illegal_insn;
  } decoder_ctrl_t;

  // Payload handed from ID to execute
  typedef struct packed {
    decoder_ctrl_t           ctrl;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [4:0]              rd;
    logic [`RVDEC_ILEN-1:0]  imm;
  } id_ex_t;

  // Every unit disabled, only the illegal flag raised
  localparam decoder_ctrl_t DECODER_CTRL_ILLEGAL_INSN = '{
    alu_en:       1'b0,
    alu_op:       ALU_ADD,
    alu_op_b_imm: 1'b0,
    mul_en:       1'b0,
    mul_op:       MUL_MUL,
    sys_en:       1'b0,
    sys_wfe_insn: 1'b0,
    rf_we:        1'b0,
    illegal_insn: 1'b1
  };

endpackage

//--- rvdec_i_decoder.sv
// Combinational sub-decoder for the OP and OP-IMM integer ALU group, used inside rvdec_decoder
`timescale 1ns/1ps
`include "rvdec_defs.svh"

module rvdec_i_decoder (
  input  logic [`RVDEC_ILEN-1:0]  instr_rdata_i,
  output rvdec_pkg::decoder_ctrl_t decoder_ctrl_o
);

  // Instruction fields
  logic [6:0]         opcode;
  logic [2:0]         funct3;
  logic [6:0]         funct7;

  // Classification result
  logic               legal;
  rvdec_pkg::alu_op_e alu_op;
  logic               op_b_imm;

  assign opcode = instr_rdata_i[6:0];
  assign funct3 = instr_rdata_i[14:12];
  assign funct7 = instr_rdata_i[31:25];

  //////////////////////////////
  // Field classification
  //////////////////////////////

  always_comb begin
    legal    = 1'b0;
    alu_op   = rvdec_pkg::ALU_ADD;
    op_b_imm = 1'b0;

    unique case (opcode)
      rvdec_pkg::OPCODE_OP: begin
        // Register-register forms
        if (funct7 == 7'b000_0000) begin
          legal = 1'b1;
          unique case (funct3)
            3'b000: alu_op = rvdec_pkg::ALU_ADD;
            3'b001: alu_op = rvdec_pkg::ALU_SLL;
            3'b010: alu_op = rvdec_pkg::ALU_SLT;
            3'b011: alu_op = rvdec_pkg::ALU_SLTU;
            3'b100: alu_op = rvdec_pkg::ALU_XOR;
            3'b101: alu_op = rvdec_pkg::ALU_SRL;
            3'b110: alu_op = rvdec_pkg::ALU_OR;
            3'b111: alu_op = rvdec_pkg::ALU_AND;
          endcase
        end else if (funct7 == 7'b010_0000) begin
          // Alternate encoding only exists for SUB and SRA
          if (funct3 == 3'b000) begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_SUB;
          end else if (funct3 == 3'b101) begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_SRA;
          end
        end
        // funct7 0000001 is left to the M decoder
      end

      rvdec_pkg::OPCODE_OP_IMM: begin
        // Operand B is the I-immediate
        op_b_imm = 1'b1;
        unique case (funct3)
          3'b000: begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_ADD;
          end
          3'b010: begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_SLT;
          end
          3'b011: begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_SLTU;
          end
          3'b100: begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_XOR;
          end
          3'b110: begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_OR;
          end
          3'b111: begin
            legal  = 1'b1;
            alu_op = rvdec_pkg::ALU_AND;
          end
          3'b001: begin
            // Shift amount is 5 bits on RV32, upper bits must be zero
            legal  = (funct7 == 7'b000_0000);
            alu_op = rvdec_pkg::ALU_SLL;
          end
          3'b101: begin
            // SRLI or SRAI, selected by bit 30
            if (funct7 == 7'b000_0000) begin
              legal  = 1'b1;
              alu_op = rvdec_pkg::ALU_SRL;
            end else if (funct7 == 7'b010_0000) begin
              legal  = 1'b1;
              alu_op = rvdec_pkg::ALU_SRA;
            end
          end
        endcase
      end

      default: begin
        // Not an ALU opcode
        legal = 1'b0;
      end
    endcase
  end

  //////////////////////////////
  // Control output
  //////////////////////////////

  always_comb begin
    decoder_ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (legal) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.alu_en       = 1'b1;
      decoder_ctrl_o.alu_op       = alu_op;
      decoder_ctrl_o.alu_op_b_imm = op_b_imm;
      // Every ALU instruction writes rd
      decoder_ctrl_o.rf_we        = 1'b1;
    end
  end

endmodule

//--- rvdec_m_decoder.sv
// Combinational sub-decoder for the M extension multiply/divide group, used inside rvdec_decoder
`timescale 1ns/1ps
`include "rvdec_defs.svh"

module rvdec_m_decoder (
  input  logic [`RVDEC_ILEN-1:0]  instr_rdata_i,
  output rvdec_pkg::decoder_ctrl_t decoder_ctrl_o
);

  // OP opcode with the MULDIV funct7
  logic is_muldiv;

  assign is_muldiv = (instr_rdata_i[6:0] == rvdec_pkg::OPCODE_OP) &&
                     (instr_rdata_i[31:25] == 7'b000_0001);

  always_comb begin
    // Default is no match
    decoder_ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;

    if (is_muldiv) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.mul_en       = 1'b1;
      // All eight funct3 values are defined
      // Operation code follows funct3 directly
      decoder_ctrl_o.mul_op       = rvdec_pkg::mul_op_e'(instr_rdata_i[14:12]);
      decoder_ctrl_o.rf_we        = 1'b1;
    end
  end

endmodule

//--- rvdec_x_decoder.sv
// Combinational sub-decoder for the custom WFE instruction with sleep suppression, in rvdec_decoder
`timescale 1ns/1ps
`include "rvdec_defs.svh"

module rvdec_x_decoder (
  input  logic [`RVDEC_ILEN-1:0]  instr_rdata_i,
  input  rvdec_pkg::ctrl_fsm_t     ctrl_fsm_i,
  output rvdec_pkg::decoder_ctrl_t decoder_ctrl_o
);

  // Exact WFE encoding
  // SYSTEM opcode, funct3 zero, rs1/rs2/rd and bit 25 zero, custom upper bits
  logic wfe_match;

  assign wfe_match = (instr_rdata_i[6:0] == rvdec_pkg::OPCODE_SYSTEM) &&
                     (instr_rdata_i[14:12] == 3'b000) &&
                     ({instr_rdata_i[25:15], instr_rdata_i[11:7]} == '0) &&
                     (instr_rdata_i[31:26] == `RVDEC_WFE_FUNCT6);

  always_comb begin
    decoder_ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;

    if (wfe_match) begin
      decoder_ctrl_o.illegal_insn = 1'b0;
      decoder_ctrl_o.sys_en       = 1'b1;
      // Debug may forbid sleeping
      // then WFE retires as a plain system no-op
      decoder_ctrl_o.sys_wfe_insn = ~ctrl_fsm_i.debug_wfi_no_sleep;
    end
  end

endmodule

//--- rvdec_decoder.sv
// Combining decoder: runs the three sub-decoders in parallel and merges their control structs
`timescale 1ns/1ps
`include "rvdec_defs.svh"

module rvdec_decoder (
  input  logic [`RVDEC_ILEN-1:0]  instr_rdata_i,
  input  rvdec_pkg::ctrl_fsm_t     ctrl_fsm_i,
  output rvdec_pkg::decoder_ctrl_t decoder_ctrl_o
);

  // One result per group
  rvdec_pkg::decoder_ctrl_t i_ctrl;
  rvdec_pkg::decoder_ctrl_t m_ctrl;
  rvdec_pkg::decoder_ctrl_t x_ctrl;

  //////////////////////////////
  // Sub-decoders
  //////////////////////////////

  rvdec_i_decoder i_decoder_i (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (i_ctrl)
  );

  rvdec_m_decoder m_decoder_i (
    .instr_rdata_i  (instr_rdata_i),
    .decoder_ctrl_o (m_ctrl)
  );

  // Custom group only when the extension is built in
  if (`RVDEC_X_EXT_EN != 0) begin : gen_x_decoder
    rvdec_x_decoder x_decoder_i (
      .instr_rdata_i  (instr_rdata_i),
      .ctrl_fsm_i     (ctrl_fsm_i),
      .decoder_ctrl_o (x_ctrl)
    );
  end else begin : gen_no_x_decoder
    // Without the extension WFE never gets claimed
    assign x_ctrl = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
  end

  //////////////////////////////
  // Merge
  //////////////////////////////

  // Groups are exclusive by opcode and function fields
  // so at most one result has illegal_insn low
  always_comb begin
    decoder_ctrl_o = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (!i_ctrl.illegal_insn) begin
      decoder_ctrl_o = i_ctrl;
    end else if (!m_ctrl.illegal_insn) begin
      decoder_ctrl_o = m_ctrl;
    end else if (!x_ctrl.illegal_insn) begin
      decoder_ctrl_o = x_ctrl;
    end
  end

endmodule

//--- rvdec_id_stage.sv
// Top level of the ID stage: decodes a fetched word and registers it for execute with valid/ready
`timescale 1ns/1ps
`include "rvdec_defs.svh"

module rvdec_id_stage (
  input  logic                   clk,
  input  logic                   rst_i,

  // Fetch side
  input  logic [`RVDEC_ILEN-1:0] instr_rdata_i,
  input  logic                   if_valid_i,
  output logic                   id_ready_o,

  // Controller
  input  rvdec_pkg::ctrl_fsm_t   ctrl_fsm_i,

  // Execute side
  output logic                   id_valid_o,
  output rvdec_pkg::id_ex_t      id_ex_o,
  input  logic                   ex_ready_i
);

  // Decoded control for the incoming word
  rvdec_pkg::decoder_ctrl_t dec_ctrl;

  // Next and current ID/EX payload
  rvdec_pkg::id_ex_t        id_ex_d;
  rvdec_pkg::id_ex_t        id_ex_q;

  // Output register holds a word
  logic                     valid_q;
  // Handshake on the fetch side
  logic                     accept;

  //////////////////////////////
  // Decode
  //////////////////////////////

  rvdec_decoder decoder_i (
    .instr_rdata_i  (instr_rdata_i),
    .ctrl_fsm_i     (ctrl_fsm_i),
    .decoder_ctrl_o (dec_ctrl)
  );

  // Operand fields pass through for every word, illegal ones too
  assign id_ex_d.ctrl = dec_ctrl;
  assign id_ex_d.rs1  = instr_rdata_i[19:15];
  assign id_ex_d.rs2  = instr_rdata_i[24:20];
  assign id_ex_d.rd   = instr_rdata_i[11:7];
  // I-immediate, sign-extended from bit 31
  assign id_ex_d.imm  = {{(`RVDEC_ILEN-12){instr_rdata_i[31]}}, instr_rdata_i[31:20]};

  //////////////////////////////
  // Handshake
  //////////////////////////////

  // Free slot, or the current word leaves this cycle
  assign id_ready_o = ~valid_q | ex_ready_i;
  assign accept     = if_valid_i & id_ready_o;

  // Valid flag
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else if (id_ready_o) begin
      // Refill or drain, held under back-pressure
      valid_q <= if_valid_i;
    end
  end

  // Payload only moves on an accepted word
  // no-sleep is captured here through dec_ctrl
  always_ff @(posedge clk) begin
    if (accept) begin
      id_ex_q <= id_ex_d;
    end
  end

  assign id_valid_o = valid_q;
  assign id_ex_o    = id_ex_q;

endmodule

//--- rvdec_sva.sv
// Concurrent handshake and latency checks for the ID stage, bound to rvdec_id_stage by the testbench
`timescale 1ns/1ps

module rvdec_sva (
  input logic              clk,
  input logic              rst_i,
  input logic              if_valid_i,
  input logic              id_ready_o,
  input logic              id_valid_o,
  input rvdec_pkg::id_ex_t id_ex_o,
  input logic              ex_ready_i
);

  // Fetch-side transfer
  logic accept;
  assign accept = if_valid_i && id_ready_o;

  //////////////////////////////
  // Latency and hold
  //////////////////////////////

  a_accept_to_valid: assert property (@(posedge clk) disable iff (rst_i) accept |=> id_valid_o)
    else $error("accepted word not presented one cycle later");

  // Back-pressure freezes the output
  a_hold_stable: assert property (@(posedge clk) disable iff (rst_i)
    (id_valid_o && !ex_ready_i) |=> (id_valid_o && $stable(id_ex_o)))
    else $error("output changed while execute stalled it");

  //////////////////////////////
  // Ready and reset
  //////////////////////////////

  a_ready_rule: assert property (@(posedge clk) disable iff (rst_i)
    id_ready_o == (!id_valid_o || ex_ready_i))
    else $error("id_ready_o breaks the empty-or-draining rule");

  a_valid_after_reset: assert property (@(posedge clk) rst_i |=> !id_valid_o)
    else $error("id_valid_o high right after reset");

endmodule

//--- tb_rvdec.sv
// Testbench for the ID stage: LFSR instruction stream, reference decode and in-order output checks
`timescale 1ns/1ps
`include "rvdec_defs.svh"

module tb_rvdec;

  localparam int NUM_WORDS     = 400;
  localparam int SEND_TIMEOUT  = 20000;
  localparam int DRAIN_TIMEOUT = 200;

  // Exact WFE encoding, reserved fields zero
  localparam logic [31:0] WFE_WORD = {`RVDEC_WFE_FUNCT6, 19'd0, 7'h73};

  // Accepted word and the no-sleep bit seen at its accept edge
  typedef struct packed {
    logic [`RVDEC_ILEN-1:0] word;
    logic                   no_sleep;
  } accepted_t;

  logic                   clk;
  logic                   rst_i;
  logic [`RVDEC_ILEN-1:0] instr_rdata_i;
  logic                   if_valid_i;
  logic                   id_ready_o;
  rvdec_pkg::ctrl_fsm_t   ctrl_fsm_i;
  logic                   id_valid_o;
  rvdec_pkg::id_ex_t      id_ex_o;
  logic                   ex_ready_i;

  logic [31:0]            lfsr_q;
  accepted_t              accepted_q[$];
  int                     n_checked;

  rvdec_id_stage dut_i (
    .clk           (clk),
    .rst_i         (rst_i),
    .instr_rdata_i (instr_rdata_i),
    .if_valid_i    (if_valid_i),
    .id_ready_o    (id_ready_o),
    .ctrl_fsm_i    (ctrl_fsm_i),
    .id_valid_o    (id_valid_o),
    .id_ex_o       (id_ex_o),
    .ex_ready_i    (ex_ready_i)
  );

  // Handshake properties on every instance of the top level
  bind rvdec_id_stage rvdec_sva sva_i (
    .clk        (clk),
    .rst_i      (rst_i),
    .if_valid_i (if_valid_i),
    .id_ready_o (id_ready_o),
    .id_valid_o (id_valid_o),
    .id_ex_o    (id_ex_o),
    .ex_ready_i (ex_ready_i)
  );

  always #2 clk = ~clk;

  //////////////////////////////
  // Random source
  //////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit, newest bit lands in bit 0
  task automatic take_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
  endtask

  // Class first, then random fields
  task automatic make_instr(output logic [`RVDEC_ILEN-1:0] word);
    logic [31:0] cls;
    logic [31:0] r;
    logic [31:0] x;
    take_bits(3, cls);
    take_bits(25, r);
    take_bits(7, x);
    case (cls[2:0])
      3'd0: word = {(r[24] ? 7'h20 : 7'h00), r[17:0], 7'h33};
      // OP-IMM, half with a well-formed shift funct7
      3'd1: word = x[0] ? {(r[24] ? 7'h20 : 7'h00), r[17:0], 7'h13} : {r[24:0], 7'h13};
      3'd2: word = {7'h01, r[17:0], 7'h33};
      3'd3: word = WFE_WORD;
      // WFE with one bit flipped
      3'd4: word = WFE_WORD ^ (32'd1 << x[4:0]);
      3'd5: word = {r[24:0], x[6:0]};
      3'd6: word = {r[24:0], 7'h33};
      default: word = {r[24:0], 7'h73};
    endcase
  endtask

  //////////////////////////////
  // Reference decode
  //////////////////////////////

  function automatic rvdec_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0: return alt ? rvdec_pkg::ALU_SUB : rvdec_pkg::ALU_ADD;
      3'd1: return rvdec_pkg::ALU_SLL;
      3'd2: return rvdec_pkg::ALU_SLT;
      3'd3: return rvdec_pkg::ALU_SLTU;
      3'd4: return rvdec_pkg::ALU_XOR;
      3'd5: return alt ? rvdec_pkg::ALU_SRA : rvdec_pkg::ALU_SRL;
      3'd6: return rvdec_pkg::ALU_OR;
      default: return rvdec_pkg::ALU_AND;
    endcase
  endfunction

  function automatic rvdec_pkg::mul_op_e mul_from_funct3(input logic [2:0] f3);
    case (f3)
      3'd0: return rvdec_pkg::MUL_MUL;
      3'd1: return rvdec_pkg::MUL_MULH;
      3'd2: return rvdec_pkg::MUL_MULHSU;
      3'd3: return rvdec_pkg::MUL_MULHU;
      3'd4: return rvdec_pkg::MUL_DIV;
      3'd5: return rvdec_pkg::MUL_DIVU;
      3'd6: return rvdec_pkg::MUL_REM;
      default: return rvdec_pkg::MUL_REMU;
    endcase
  endfunction

  function automatic rvdec_pkg::id_ex_t ref_decode(input accepted_t a);
    rvdec_pkg::id_ex_t e;
    logic [6:0]        f7;
    logic [2:0]        f3;
    logic              shift;
    f7     = a.word[31:25];
    f3     = a.word[14:12];
    shift  = (f3 == 3'd1) || (f3 == 3'd5);
    e.ctrl = rvdec_pkg::DECODER_CTRL_ILLEGAL_INSN;
    if (a.word[6:0] == 7'h33 && f7 == 7'h01) begin
      e.ctrl.mul_en = 1'b1;
      e.ctrl.mul_op = mul_from_funct3(f3);
    end else if (a.word[6:0] == 7'h33 &&
                 (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) begin
      e.ctrl.alu_en = 1'b1;
      e.ctrl.alu_op = alu_from_funct3(f3, f7[5]);
    end else if (a.word[6:0] == 7'h13 &&
                 (!shift || f7 == 7'h00 || (f3 == 3'd5 && f7 == 7'h20))) begin
      // Bit 30 of an immediate only selects SRAI
      e.ctrl.alu_en       = 1'b1;
      e.ctrl.alu_op_b_imm = 1'b1;
      e.ctrl.alu_op       = alu_from_funct3(f3, shift && f7[5]);
    end else if (`RVDEC_X_EXT_EN != 0 && a.word == WFE_WORD) begin
      e.ctrl.sys_en       = 1'b1;
      e.ctrl.sys_wfe_insn = !a.no_sleep;
    end
    e.ctrl.illegal_insn = !(e.ctrl.alu_en || e.ctrl.mul_en || e.ctrl.sys_en);
    // ALU and M results go to rd, WFE writes nothing
    e.ctrl.rf_we = e.ctrl.alu_en || e.ctrl.mul_en;
    e.rs1        = a.word[19:15];
    e.rs2        = a.word[24:20];
    e.rd         = a.word[11:7];
    e.imm        = {{20{a.word[31]}}, a.word[31:20]};
    return e;
  endfunction

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic send_words();
    logic [31:0]            r;
    logic [`RVDEC_ILEN-1:0] word;
    int                     sent;
    int                     cycles;
    sent   = 0;
    cycles = 0;
    while (sent < NUM_WORDS) begin
      @(posedge clk);
      cycles++;
      if (cycles > SEND_TIMEOUT) begin
        $display("stimulus timed out with %0d of %0d words accepted", sent, NUM_WORDS);
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
      if (if_valid_i && id_ready_o) begin
        sent++;
      end
      // Word held while the stage stalls it
      if (!if_valid_i || id_ready_o) begin
        take_bits(2, r);
        if (sent < NUM_WORDS && r[1:0] != 2'd0) begin
          make_instr(word);
          instr_rdata_i <= word;
          if_valid_i    <= 1'b1;
        end else begin
          if_valid_i <= 1'b0;
        end
      end
      take_bits(2, r);
      ex_ready_i <= (r[1:0] != 2'd0);
      // No-sleep moves freely, only its value at accept counts
      take_bits(1, r);
      ctrl_fsm_i.debug_wfi_no_sleep <= r[0];
    end
  endtask

  // Execute always ready until the stage is empty
  task automatic drain();
    int cycles;
    cycles     = 0;
    ex_ready_i <= 1'b1;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        $display("drain timed out with %0d words still pending", accepted_q.size());
        $display("TESTBENCH FAILED");
        $fatal(1);
      end
    end while (accepted_q.size() != 0 || id_valid_o);
  endtask

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // Old values at the edge are the ones of the transfer cycle
  always @(posedge clk) begin : monitor
    accepted_t         item;
    rvdec_pkg::id_ex_t exp;
    if (!rst_i) begin
      if (id_valid_o && ex_ready_i) begin
        assert (accepted_q.size() != 0) else begin
          $display("output transfer at %0t with no accepted word pending", $time);
          $display("TESTBENCH FAILED");
          $fatal(1);
        end
        if (accepted_q.size() != 0) begin
          item = accepted_q.pop_front();
          exp  = ref_decode(item);
          assert (id_ex_o === exp) else begin
            $display("mismatch at %0t: word %h no_sleep %b got %h expected %h",
                     $time, item.word, item.no_sleep, id_ex_o, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
          end
          n_checked++;
        end
      end
      if (if_valid_i && id_ready_o) begin
        item.word     = instr_rdata_i;
        item.no_sleep = ctrl_fsm_i.debug_wfi_no_sleep;
        accepted_q.push_back(item);
      end
    end
  end

  initial begin
    clk           = 1'b0;
    rst_i         = 1'b1;
    instr_rdata_i = '0;
    if_valid_i    = 1'b0;
    ctrl_fsm_i    = '0;
    ex_ready_i    = 1'b0;
    lfsr_q        = 32'hf2d2f662;
    n_checked     = 0;
    repeat (4) @(posedge clk);
    rst_i <= 1'b0;
    send_words();
    drain();
    if (n_checked == NUM_WORDS && accepted_q.size() == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("mismatch at %0t: %0d of %0d transfers checked", $time, n_checked, NUM_WORDS);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  end

endmodule

//--- rvdec.f
+incdir+.
rvdec_pkg.sv
rvdec_i_decoder.sv
rvdec_m_decoder.sv
rvdec_x_decoder.sv
rvdec_decoder.sv
rvdec_id_stage.sv
rvdec_sva.sv
tb_rvdec.sv

//--- Makefile
# Verilator build, run and lint for the ID stage testbench

VERILATOR  ?= verilator
TOP        ?= tb_rvdec
FILELIST   ?= rvdec.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
